/* hdl/mesm6_alu.sv */
////////////////////
// Top of the 48-bit arithmetic unit
// Control with bit counter, shifter and field engine
////////////////////

`timescale 1ns/1ns

module mesm6_alu
    import mesm6_word_pkg::*, mesm6_alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  alu_cmd_t cmd,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    output alu_res_t res,
    output logic     res_valid,
    input  logic     res_ready
);

    logic [count_width-1:0] ones;
    logic [count_width-1:0] lead;
    word_t                  count_a;

    logic  shift_start;
    logic  shift_done;
    word_t shift_a;
    word_u shift_b;
    word_t shift_acc;
    word_t shift_y;

    logic  field_start;
    logic  field_pack;
    logic  field_done;
    word_t field_a;
    word_t field_mask;
    word_t field_acc;

    mesm6_alu_control mesm6_alu_control_i (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .res         (res),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .ones        (ones),
        .lead        (lead),
        .count_a     (count_a),
        .shift_start (shift_start),
        .shift_a     (shift_a),
        .shift_b     (shift_b),
        .shift_done  (shift_done),
        .shift_acc   (shift_acc),
        .shift_y     (shift_y),
        .field_start (field_start),
        .field_pack  (field_pack),
        .field_a     (field_a),
        .field_mask  (field_mask),
        .field_done  (field_done),
        .field_acc   (field_acc)
    );

    mesm6_bit_count mesm6_bit_count_i (
        .a    (count_a),
        .ones (ones),
        .lead (lead)
    );

    mesm6_shift_engine mesm6_shift_engine_i (
        .clk   (clk),
        .rst   (rst),
        .start (shift_start),
        .a     (shift_a),
        .b     (shift_b),
        .done  (shift_done),
        .acc   (shift_acc),
        .y     (shift_y)
    );

    mesm6_field_engine mesm6_field_engine_i (
        .clk   (clk),
        .rst   (rst),
        .start (field_start),
        .pack  (field_pack),
        .a     (field_a),
        .mask  (field_mask),
        .done  (field_done),
        .acc   (field_acc)
    );

endmodule

/* hdl/mesm6_alu_control.sv */
////////////////////
// Sequencer of the arithmetic unit
// Accumulator, Y and carry registers
// Logic ops, Y transfers, end-around adder
// Command and result handshakes
////////////////////

`timescale 1ns/1ns

module mesm6_alu_control
    import mesm6_word_pkg::*, mesm6_alu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  alu_cmd_t               cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    output alu_res_t               res,
    output logic                   res_valid,
    input  logic                   res_ready,
    input  logic [count_width-1:0] ones,
    input  logic [count_width-1:0] lead,
    output word_t                  count_a,
    output logic                   shift_start,
    output word_t                  shift_a,
    output word_u                  shift_b,
    input  logic                   shift_done,
    input  word_t                  shift_acc,
    input  word_t                  shift_y,
    output logic                   field_start,
    output logic                   field_pack,
    output word_t                  field_a,
    output word_t                  field_mask,
    input  logic                   field_done,
    input  word_t                  field_acc
);

    typedef enum logic [2:0] {
        st_idle,
        st_add_b,
        st_add_carry,
        st_wait,
        st_result
    } state_t;

    state_t              state;
    word_t               acc;
    word_t               y;
    word_t               b_r;
    word_t               add_x;
    word_t               add_y;
    logic                carry;
    logic                accept;
    logic [word_width:0] sum;

    assign cmd_ready = (state == st_idle);
    assign res_valid = (state == st_result);
    assign accept    = cmd_valid && cmd_ready;

    assign res.acc = acc;
    assign res.y   = y;

    // Helpers see the command operands on the accept cycle
    assign count_a     = cmd.a;
    assign shift_start = accept && (cmd.op == op_shift);
    assign shift_a     = cmd.a;
    assign shift_b     = cmd.b;
    assign field_start = accept && (cmd.op == op_pack || cmd.op == op_unpack);
    assign field_pack  = (cmd.op == op_pack);
    assign field_a     = cmd.a;
    assign field_mask  = cmd.b.w;

    // Shared adder: A+B on accept, acc+B, then acc+carry
    always_comb begin
        add_x = (state == st_idle) ? cmd.a : acc;
        case (state)
            st_idle:      add_y = cmd.b.w;
            st_add_carry: add_y = word_t'(carry);
            default:      add_y = b_r;
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y};

    // B is needed again in the second step of count and clz
    always_ff @(posedge clk) begin
        if (accept) begin
            b_r <= cmd.b.w;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            acc   <= '0;
            y     <= '0;
            carry <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_result;
                        case (cmd.op)
                            op_and: begin
                                acc <= cmd.a & cmd.b.w;
                                y   <= '0;
                            end
                            op_or: begin
                                acc <= cmd.a | cmd.b.w;
                                y   <= '0;
                            end
                            op_xor: begin
                                acc <= cmd.a ^ cmd.b.w;
                                y   <= cmd.a;
                            end
                            op_set_y: y   <= cmd.a;
                            op_yta:   acc <= y;
                            op_add_carry: begin
                                {carry, acc} <= sum;
                                y            <= '0;
                                state        <= st_add_carry;
                            end
                            op_count: begin
                                acc   <= word_t'(ones);
                                y     <= '0;
                                state <= st_add_b;
                            end
                            op_clz: begin
                                acc   <= word_t'(lead);
                                // Leading one falls off the top
                                y     <= cmd.a << lead;
                                state <= st_add_b;
                            end
                            op_shift: state <= st_wait;
                            op_pack, op_unpack: begin
                                y     <= '0;
                                state <= st_wait;
                            end
                            default: state <= st_result;
                        endcase
                    end
                end
                st_add_b: begin
                    {carry, acc} <= sum;
                    state        <= st_add_carry;
                end
                st_add_carry: begin
                    // Cannot carry out again after the first add
                    acc   <= sum[word_width-1:0];
                    state <= st_result;
                end
                st_wait: begin
                    if (shift_done) begin
                        acc   <= shift_acc;
                        y     <= shift_y;
                        state <= st_result;
                    end else if (field_done) begin
                        acc   <= field_acc;
                        state <= st_result;
                    end
                end
                st_result: begin
                    if (res_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* hdl/mesm6_alu_pkg.sv */
////////////////////
// Port types of the arithmetic unit
// Opcode set, command and result structs
////////////////////

package mesm6_alu_pkg;

    import mesm6_word_pkg::*;

    localparam int op_width = 4;

    // Integer and bit-field operations of the unit
    typedef enum logic [op_width-1:0] {
        op_and,
        op_or,
        op_xor,
        op_add_carry,
        op_count,
        op_clz,
        op_shift,
        op_pack,
        op_unpack,
        op_set_y,
        op_yta
    } alu_op_t;

    // Command word: opcode and two operands
    // B is a union since the shift reads its exponent field
    typedef struct packed {
        alu_op_t op;
        word_t   a;
        word_u   b;
    } alu_cmd_t;

    // Result: accumulator and Y register
    typedef struct packed {
        word_t acc;
        word_t y;
    } alu_res_t;

endpackage

/* hdl/mesm6_bit_count.sv */
////////////////////
// Combinational bit counter
// Ones count and leading-zero-plus-one count
////////////////////

`timescale 1ns/1ns

module mesm6_bit_count
    import mesm6_word_pkg::*;
(
    input  word_t                  a,
    output logic [count_width-1:0] ones,
    output logic [count_width-1:0] lead
);

    // Lead is the position of the highest one counted from the top,
    // starting at 1, and 0 when the word is zero
    always_comb begin
        ones = '0;
        lead = '0;
        for (int i = 0; i < word_width; i++) begin
            ones = ones + count_width'(a[i]);
            // Higher bits come later and win
            if (a[i]) begin
                lead = count_width'(word_width - i);
            end
        end
    end

endmodule

/* hdl/mesm6_field_engine.sv */
////////////////////
// Serial bit pack and unpack under a mask
// Pack walks the mask up from bit 0
// Unpack walks all 48 mask bits from the top
////////////////////

`timescale 1ns/1ns

module mesm6_field_engine
    import mesm6_word_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  pack,
    input  word_t a,
    input  word_t mask,
    output logic  done,
    output word_t acc
);

    logic                   busy;
    logic                   pack_r;
    logic                   last;
    word_t                  src;
    word_t                  mask_r;
    logic [count_width-1:0] cnt;

    // Pack ends once no set mask bit is left above the current one
    // Unpack ends after a fixed 48 steps
    assign last = pack_r ? (mask_r[word_width-1:1] == '0)
                         : (cnt == count_width'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (busy && last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            src    <= a;
            mask_r <= mask;
            pack_r <= pack;
            acc    <= '0;
            cnt    <= count_width'(word_width);
        end else if (busy) begin
            cnt <= cnt - count_width'(1);
            if (pack_r) begin
                // Selected source bits enter at the top and drift down
                if (mask_r[0]) begin
                    acc <= {src[0], acc[word_width-1:1]};
                end
                mask_r <= mask_r >> 1;
                src    <= src >> 1;
            end else begin
                // Next source bit is consumed only at a set mask position
                acc <= {acc[word_width-2:0], src[word_width-1] & mask_r[word_width-1]};
                if (mask_r[word_width-1]) begin
                    src <= src << 1;
                end
                mask_r <= mask_r << 1;
            end
        end
    end

endmodule

/* hdl/mesm6_shift_engine.sv */
////////////////////
// Iterative shifter for the accumulator/Y pair
// Count taken from the exponent of B
// One to four bit positions per cycle
////////////////////

`timescale 1ns/1ns

module mesm6_shift_engine
    import mesm6_word_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  word_t a,
    input  word_u b,
    output logic  done,
    output word_t acc,
    output word_t y
);

    logic                    busy;
    logic [exp_width-1:0]    exp_r;
    logic [2*word_width-1:0] pair;
    logic [2*word_width-1:0] pair_right;
    logic [2*word_width-1:0] pair_swap;
    logic [2:0]              step;
    logic                    go_right;

    // Exponent above the bias moves right, below moves left
    assign go_right = exp_r[exp_width-1];

    // Step size brings the exponent to a multiple of four first,
    // then four at a time
    always_comb begin
        if (go_right) begin
            step = (exp_r[1:0] == 2'b00) ? 3'd4 : {1'b0, exp_r[1:0]};
        end else begin
            step = 3'd4 - {1'b0, exp_r[1:0]};
        end
    end

    assign pair_right = pair >> step;

    // Left shifts run on the swapped pair {y, acc}
    assign pair_swap = {pair[word_width-1:0], pair[2*word_width-1:word_width]} << step;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
            end else if (busy && exp_r == exp_bias) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            pair  <= {a, {word_width{1'b0}}};
            exp_r <= b.f.exp;
        end else if (busy && exp_r != exp_bias) begin
            if (go_right) begin
                pair  <= pair_right;
                exp_r <= exp_r - exp_width'(step);
            end else begin
                pair  <= {pair_swap[word_width-1:0], pair_swap[2*word_width-1:word_width]};
                exp_r <= exp_r + exp_width'(step);
            end
        end
    end

    assign acc = pair[2*word_width-1:word_width];
    assign y   = pair[word_width-1:0];

endmodule

/* hdl/mesm6_word_pkg.sv */
////////////////////
// Machine word format of the 48-bit unit
// Width constants, shift bias, count width
// Raw word and exponent/mantissa views
////////////////////

package mesm6_word_pkg;

    // Word and field widths
    localparam int word_width  = 48;
    localparam int exp_width   = 7;
    localparam int mant_width  = 41;

    // Exponent value that leaves a word in place
    localparam logic [exp_width-1:0] exp_bias = 7'd64;

    // Ones count and leading-zero count need 6 bits for 0..48
    localparam int count_width = 6;

    typedef logic [word_width-1:0] word_t;

    // Exponent sits above the mantissa
    typedef struct packed {
        logic [exp_width-1:0]  exp;
        logic [mant_width-1:0] mant;
    } float_word_t;

    // One word, read either as raw bits or as exponent and mantissa
    typedef union packed {
        word_t       w;
        float_word_t f;
    } word_u;

endpackage

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator, then check the log
set -e

verilator --binary --timing --assert --top-module mesm6_alu_tb \
    -f sim.f -Mdir obj_dir -o mesm6_alu_sim

./obj_dir/mesm6_alu_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* sim.f */
hdl/mesm6_word_pkg.sv
hdl/mesm6_alu_pkg.sv
hdl/mesm6_bit_count.sv
hdl/mesm6_shift_engine.sv
hdl/mesm6_field_engine.sv
hdl/mesm6_alu_control.sv
hdl/mesm6_alu.sv
tb/mesm6_alu_sva.sv
tb/mesm6_alu_tb.sv

/* tb/mesm6_alu_sva.sv */
////////////////////
// Protocol assertions of the arithmetic unit
// Result hold, command blocking, reset state
// Fixed latencies of logic and count ops
////////////////////

`timescale 1ns/1ns

module mesm6_alu_sva
    import mesm6_alu_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input alu_cmd_t cmd,
    input logic     cmd_valid,
    input logic     cmd_ready,
    input alu_res_t res,
    input logic     res_valid,
    input logic     res_ready
);

    int   fail_count = 0;
    logic accept;
    logic logic_op;
    logic count_op;

    assign accept   = cmd_valid && cmd_ready;
    assign logic_op = (cmd.op == op_and) || (cmd.op == op_or) || (cmd.op == op_xor);
    assign count_op = (cmd.op == op_count) || (cmd.op == op_clz);

    // Stalled result keeps its value until taken
    res_hold: assert property (@(posedge clk) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res))
    else begin
        fail_count++;
        $error("result changed or dropped while res_ready was low");
    end

    cmd_block: assert property (@(posedge clk) disable iff (rst)
        res_valid |-> !cmd_ready)
    else begin
        fail_count++;
        $error("cmd_ready high while a result is pending");
    end

    rst_clear: assert property (@(posedge clk)
        rst |=> !res_valid)
    else begin
        fail_count++;
        $error("res_valid high in the cycle after reset");
    end

    logic_latency: assert property (@(posedge clk) disable iff (rst)
        $past(accept && logic_op) |-> res_valid)
    else begin
        fail_count++;
        $error("logic op result not valid one cycle after accept");
    end

    // Count and clz go through add B and add carry first
    count_latency: assert property (@(posedge clk) disable iff (rst)
        $past(accept && count_op, 3) |-> res_valid && !$past(res_valid) && !$past(res_valid, 2))
    else begin
        fail_count++;
        $error("count or clz result not valid exactly three cycles after accept");
    end

endmodule

bind mesm6_alu mesm6_alu_sva mesm6_alu_sva_i (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
);

/* tb/mesm6_alu_tb.sv */
////////////////////
// Testbench of the 48-bit arithmetic unit
// Clock, reset, command and result drivers
// Reference model of acc and Y, value checks
////////////////////

`timescale 1ns/1ns

module mesm6_alu_tb
    import mesm6_word_pkg::*, mesm6_alu_pkg::*;
();

    localparam int num_ops     = 200;
    localparam int cycle_limit = num_ops * 60;

    logic     clk;
    logic     rst;
    alu_cmd_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;
    alu_res_t res;
    logic     res_valid;
    logic     res_ready;

    integer  seed     = 32'h528d;
    int      errors   = 0;
    int      cycles   = 0;
    bit      stall_en = 1'b0;
    word_t   m_acc    = '0;
    word_t   m_y      = '0;
    word_t   got_acc;
    word_t   corners[6] = '{48'h0, 48'hffff_ffff_ffff, 48'h1, 48'h8000_0000_0000,
                            48'h0000_0100_0000, 48'h5555_5555_5555};
    int      shift_exps[5] = '{64, 65, 127, 63, 0};
    alu_op_t logic_ops[5]  = '{op_and, op_or, op_xor, op_set_y, op_yta};

    mesm6_alu mesm6_alu_i (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .res       (res),
        .res_valid (res_valid),
        .res_ready (res_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Watchdog on the total run length
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic word_t rand_word();
        return {16'($random(seed)), 32'($random(seed))};
    endfunction

    function automatic word_t with_exp(int e, word_t m);
        return {exp_width'(e), m[mant_width-1:0]};
    endfunction

    // Carry out of the sum goes back in at bit 0
    function automatic word_t add_ea(word_t x, word_t z);
        logic [word_width:0] s;
        s = {1'b0, x} + {1'b0, z};
        return s[word_width-1:0] + word_t'(s[word_width]);
    endfunction

    function automatic word_t ones_of(word_t x);
        word_t n;
        n = '0;
        for (int i = 0; i < word_width; i++) begin
            n = n + word_t'(x[i]);
        end
        return n;
    endfunction

    // Top one counts as 1 at bit 47
    function automatic word_t lead_of(word_t x);
        for (int i = word_width - 1; i >= 0; i--) begin
            if (x[i]) begin
                return word_t'(word_width - i);
            end
        end
        return '0;
    endfunction

    function automatic word_t pack_of(word_t a, word_t m);
        word_t t;
        int    k;
        t = '0;
        k = 0;
        for (int i = 0; i < word_width; i++) begin
            if (m[i]) begin
                t[k] = a[i];
                k++;
            end
        end
        return t << (word_width - k);
    endfunction

    function automatic word_t unpack_of(word_t a, word_t m);
        word_t r;
        int    j;
        r = '0;
        j = word_width - 1;
        for (int i = word_width - 1; i >= 0; i--) begin
            if (m[i]) begin
                r[i] = a[j];
                j--;
            end
        end
        return r;
    endfunction

    task automatic predict(input alu_op_t op, input word_t a, input word_t b);
        logic [2*word_width-1:0] p;
        int                      e;
        e = int'(b[word_width-1:mant_width]);
        case (op)
            op_and, op_or: begin
                m_acc = (op == op_and) ? (a & b) : (a | b);
                m_y   = '0;
            end
            op_xor: begin
                m_acc = a ^ b;
                m_y   = a;
            end
            op_set_y: m_y   = a;
            op_yta:   m_acc = m_y;
            op_add_carry, op_count: begin
                m_acc = add_ea((op == op_count) ? ones_of(a) : a, b);
                m_y   = '0;
            end
            op_clz: begin
                m_acc = add_ea(lead_of(a), b);
                m_y   = a << lead_of(a);
            end
            op_shift: begin
                if (e >= 64) begin
                    p     = {a, {word_width{1'b0}}} >> (e - 64);
                    m_acc = p[2*word_width-1:word_width];
                    m_y   = p[word_width-1:0];
                end else begin
                    // Left shifts move the pair with Y on top
                    p     = {{word_width{1'b0}}, a} << (64 - e);
                    m_y   = p[2*word_width-1:word_width];
                    m_acc = p[word_width-1:0];
                end
            end
            default: begin
                m_acc = (op == op_pack) ? pack_of(a, b) : unpack_of(a, b);
                m_y   = '0;
            end
        endcase
    endtask

    task automatic run_op(input alu_op_t op, input word_t a, input word_t b);
        int stall;
        predict(op, a, b);
        @(negedge clk);
        cmd.op    = op;
        cmd.a     = a;
        cmd.b.w   = b;
        cmd_valid = 1'b1;
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
        while (!res_valid) begin
            @(negedge clk);
        end
        stall = stall_en ? ($random(seed) & 7) : 0;
        repeat (stall) @(negedge clk);
        assert (res.acc == m_acc) else begin
            errors++;
            $display("Mismatch at %0t: res.acc got %h expected %h", $time, res.acc, m_acc);
        end
        assert (res.y == m_y) else begin
            errors++;
            $display("Mismatch at %0t: res.y got %h expected %h", $time, res.y, m_y);
        end
        got_acc   = res.acc;
        res_ready = 1'b1;
        @(negedge clk);
        res_ready = 1'b0;
    endtask

    // Unpacking a packed word under the same mask gives a and b
    task automatic pack_round_trip(input word_t a, input word_t b);
        run_op(op_pack, a, b);
        run_op(op_unpack, got_acc, b);
        assert (got_acc == (a & b)) else begin
            errors++;
            $display("Mismatch at %0t: unpacked acc got %h expected %h", $time, got_acc, a & b);
        end
    endtask

    initial begin
        alu_op_t op;
        cmd       = '0;
        cmd_valid = 1'b0;
        res_ready = 1'b0;
        rst       = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < 30; n++) begin
            run_op(logic_ops[$unsigned($random(seed)) % 5], rand_word(), rand_word());
        end

        foreach (corners[i]) begin
            run_op(op_add_carry, corners[i], '1);
            run_op(op_count, corners[i], rand_word());
            run_op(op_clz, corners[i], corners[(i + 1) % 6]);
        end
        for (int n = 0; n < 8; n++) begin
            run_op(op_add_carry, rand_word(), rand_word());
            run_op(op_count, rand_word(), rand_word());
            run_op(op_clz, rand_word(), rand_word());
        end

        foreach (shift_exps[i]) begin
            run_op(op_shift, rand_word(), with_exp(shift_exps[i], rand_word()));
        end
        for (int n = 0; n < 10; n++) begin
            run_op(op_shift, rand_word(), with_exp($unsigned($random(seed)) % 128, rand_word()));
        end

        for (int n = 0; n < 8; n++) begin
            run_op(op_pack, rand_word(), rand_word());
            run_op(op_unpack, rand_word(), rand_word());
            pack_round_trip(rand_word(), rand_word());
        end
        pack_round_trip(rand_word(), '0);
        pack_round_trip(rand_word(), '1);

        // Mixed traffic with a slow result consumer
        stall_en = 1'b1;
        for (int n = 0; n < 25; n++) begin
            op = alu_op_t'(op_width'($unsigned($random(seed)) % 11));
            run_op(op, rand_word(), rand_word());
        end

        @(negedge clk);
        $display("Errors: %0d value mismatches, %0d protocol failures",
                 errors, mesm6_alu_i.mesm6_alu_sva_i.fail_count);
        if (errors == 0 && mesm6_alu_i.mesm6_alu_sva_i.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
